//--- rtl/cfgPkg.sv
package cfgPkg;

  // data path widths
  localparam int WordWidth = 32;
  localparam int RowIdxWidth = 2;
  localparam int FrameIdxWidth = 2;

  typedef logic [WordWidth-1:0] cfgWordT;
  typedef logic [RowIdxWidth-1:0] rowIdxT;
  typedef logic [FrameIdxWidth-1:0] frameIdxT;
  typedef logic [WordWidth-1:0] frameBitsT;

  // fabric geometry
  localparam int NumberOfRows = 4;
  localparam int FramesPerRow = 4;

  // configuration word protocol
  localparam cfgWordT SyncWord = 32'hFAB0FAB1;
  localparam int DesyncFlag = 20;
  localparam int RowFieldLsb = 30;
  localparam int FrameFieldLsb = 0;

  // uart receiver
  localparam logic [7:0] UartSyncByte = 8'hA5;
  localparam int ClocksPerBit = 8;
  localparam int UartIdleClocks = 160;

  localparam int BaudCntWidth = $clog2(ClocksPerBit);
  typedef logic [BaudCntWidth-1:0] baudCntT;
  localparam baudCntT BaudLast = baudCntT'(ClocksPerBit - 1);
  // start bit is checked half a bit in
  localparam baudCntT BaudHalf = baudCntT'(ClocksPerBit / 2 - 1);

  localparam int UartIdleWidth = $clog2(UartIdleClocks);
  typedef logic [UartIdleWidth-1:0] uartIdleCntT;
  localparam uartIdleCntT UartIdleLast = uartIdleCntT'(UartIdleClocks - 1);

  // bit-bang port
  localparam int BitbangIdleClocks = 64;
  localparam int BbIdleWidth = $clog2(BitbangIdleClocks);
  typedef logic [BbIdleWidth-1:0] bbIdleCntT;
  localparam bbIdleCntT BbIdleLast = bbIdleCntT'(BitbangIdleClocks - 1);

  typedef enum logic [1:0] {
    waitSync,
    waitHeader,
    waitData
  } cfgStateT;

endpackage

//--- rtl/configUart.sv
`timescale 1ns/1ps

module configUart (
  input  logic            CLK,
  input  logic            rstN,
  input  logic            Rx,
  output cfgPkg::cfgWordT uartWord,
  output logic            uartStrobe,
  output logic            uartActive,
  output logic            uartLed
);

  typedef enum logic [1:0] {
    rxIdle,
    rxStart,
    rxData,
    rxStop
  } rxStateT;

  rxStateT rxState;
  logic rxMeta;
  logic rxSync;
  cfgPkg::baudCntT baudCnt;
  logic [2:0] bitCnt;
  logic [7:0] rxByte;
  logic byteDone;
  logic [1:0] byteCnt;
  cfgPkg::uartIdleCntT idleCnt;
  logic lineIdle;

  // line idles high, so the synchroniser resets to one
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= Rx;
      rxSync <= rxMeta;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      rxState <= rxIdle;
      baudCnt <= '0;
      bitCnt <= '0;
    end else begin
      case (rxState)
        rxIdle: begin
          baudCnt <= '0;
          if (!rxSync) begin
            rxState <= rxStart;
          end
        end
        rxStart: begin
          if (baudCnt == cfgPkg::BaudHalf) begin
            baudCnt <= '0;
            bitCnt <= '0;
            // glitch shorter than half a bit is dropped
            rxState <= rxSync ? rxIdle : rxData;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        rxData: begin
          if (baudCnt == cfgPkg::BaudLast) begin
            baudCnt <= '0;
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == 3'd7) begin
              rxState <= rxStop;
            end
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        default: begin
          if (baudCnt == cfgPkg::BaudLast) begin
            rxState <= rxIdle;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first on the wire
  always_ff @(posedge CLK) begin
    if (rxState == rxData && baudCnt == cfgPkg::BaudLast) begin
      rxByte <= {rxSync, rxByte[7:1]};
    end
  end

  // stop bit sampled high, byte is good
  assign byteDone = (rxState == rxStop) && (baudCnt == cfgPkg::BaudLast) && rxSync;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      idleCnt <= '0;
    end else if (!rxSync) begin
      idleCnt <= '0;
    end else if (!lineIdle) begin
      idleCnt <= idleCnt + 1'b1;
    end
  end

  assign lineIdle = (idleCnt == cfgPkg::UartIdleLast);

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      uartActive <= 1'b0;
      uartStrobe <= 1'b0;
      uartLed <= 1'b0;
      byteCnt <= '0;
    end else begin
      uartStrobe <= 1'b0;
      if (byteDone) begin
        uartLed <= ~uartLed;
        if (uartActive) begin
          byteCnt <= byteCnt + 1'b1;
          if (byteCnt == 2'd3) begin
            uartStrobe <= 1'b1;
          end
        end else if (rxByte == cfgPkg::UartSyncByte) begin
          uartActive <= 1'b1;
          byteCnt <= '0;
        end
      end else if (uartActive && lineIdle) begin
        uartActive <= 1'b0;
        byteCnt <= '0;
      end
    end
  end

  // first byte ends up most significant
  always_ff @(posedge CLK) begin
    if (byteDone && uartActive) begin
      uartWord <= {uartWord[23:0], rxByte};
    end
  end

endmodule

//--- rtl/bitbangRx.sv
`timescale 1ns/1ps

module bitbangRx (
  input  logic            CLK,
  input  logic            rstN,
  input  logic            s_clk,
  input  logic            s_data,
  output cfgPkg::cfgWordT bbWord,
  output logic            bbStrobe,
  output logic            bbActive
);

  logic sClkMeta;
  logic sClkSync;
  logic sClkDly;
  logic sDataMeta;
  logic sDataSync;
  logic sClkRise;
  logic [4:0] bitCnt;
  cfgPkg::bbIdleCntT idleCnt;

  // data runs through the same two stages so it stays aligned with the clock
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      sClkMeta <= 1'b0;
      sClkSync <= 1'b0;
      sClkDly <= 1'b0;
      sDataMeta <= 1'b0;
      sDataSync <= 1'b0;
    end else begin
      sClkMeta <= s_clk;
      sClkSync <= sClkMeta;
      sClkDly <= sClkSync;
      sDataMeta <= s_data;
      sDataSync <= sDataMeta;
    end
  end

  assign sClkRise = sClkSync & ~sClkDly;

  always_ff @(posedge CLK) begin
    if (sClkRise) begin
      bbWord <= {bbWord[30:0], sDataSync};
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      bitCnt <= '0;
      idleCnt <= '0;
      bbStrobe <= 1'b0;
      bbActive <= 1'b0;
    end else begin
      bbStrobe <= 1'b0;
      if (sClkRise) begin
        bbActive <= 1'b1;
        idleCnt <= '0;
        bitCnt <= bitCnt + 1'b1;
        if (bitCnt == 5'd31) begin
          bbStrobe <= 1'b1;
        end
      end else if (bbActive) begin
        if (idleCnt == cfgPkg::BbIdleLast) begin
          // port went quiet, drop any partial word
          bbActive <= 1'b0;
          bitCnt <= '0;
        end else begin
          idleCnt <= idleCnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/configFsm.sv
`timescale 1ns/1ps

module configFsm (
  input  logic              CLK,
  input  logic              rstN,
  input  cfgPkg::cfgWordT   WriteData,
  input  logic              WriteStrobe,
  input  logic              FSM_Reset,
  output cfgPkg::frameBitsT FrameAddressRegister,
  output cfgPkg::rowIdxT    RowSelect,
  output cfgPkg::frameIdxT  frameSel,
  output logic              LongFrameStrobe
);

  cfgPkg::cfgStateT state;
  logic fsmResetDly;
  logic fsmResetRise;
  cfgPkg::rowIdxT rowLatched;
  cfgPkg::frameIdxT frameLatched;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      fsmResetDly <= 1'b0;
    end else begin
      fsmResetDly <= FSM_Reset;
    end
  end

  // a new serial session starts from a clean sync search
  assign fsmResetRise = FSM_Reset & ~fsmResetDly;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state <= cfgPkg::waitSync;
      LongFrameStrobe <= 1'b0;
    end else begin
      LongFrameStrobe <= 1'b0;
      if (fsmResetRise) begin
        state <= cfgPkg::waitSync;
      end else if (WriteStrobe) begin
        case (state)
          cfgPkg::waitSync: begin
            if (WriteData == cfgPkg::SyncWord) begin
              state <= cfgPkg::waitHeader;
            end
          end
          cfgPkg::waitHeader: begin
            if (WriteData[cfgPkg::DesyncFlag]) begin
              state <= cfgPkg::waitSync;
            end else begin
              state <= cfgPkg::waitData;
            end
          end
          default: begin
            LongFrameStrobe <= 1'b1;
            state <= cfgPkg::waitHeader;
          end
        endcase
      end
    end
  end

  // header fields held until the data word arrives
  always_ff @(posedge CLK) begin
    if (WriteStrobe && state == cfgPkg::waitHeader) begin
      rowLatched <= WriteData[cfgPkg::RowFieldLsb +: cfgPkg::RowIdxWidth];
      frameLatched <= WriteData[cfgPkg::FrameFieldLsb +: cfgPkg::FrameIdxWidth];
    end
  end

  always_ff @(posedge CLK) begin
    if (WriteStrobe && state == cfgPkg::waitData && !fsmResetRise) begin
      FrameAddressRegister <= WriteData;
      RowSelect <= rowLatched;
      frameSel <= frameLatched;
    end
  end

endmodule

//--- rtl/frameRowLatch.sv
`timescale 1ns/1ps

module frameRowLatch (
  input  logic                                         CLK,
  input  logic                                         rstN,
  input  cfgPkg::rowIdxT                               rowId,
  input  cfgPkg::rowIdxT                               RowSelect,
  input  cfgPkg::frameIdxT                             frameSel,
  input  logic                                         LongFrameStrobe,
  input  cfgPkg::frameBitsT                            FrameAddressRegister,
  output cfgPkg::frameBitsT [cfgPkg::FramesPerRow-1:0] rowFrames
);

  logic rowHit;

  // only the addressed row takes the frame
  assign rowHit = LongFrameStrobe && (RowSelect == rowId);

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      rowFrames <= '0;
    end else if (rowHit) begin
      rowFrames[frameSel] <= FrameAddressRegister;
    end
  end

endmodule

//--- rtl/frameReadback.sv
`timescale 1ns/1ps

module frameReadback (
  input  cfgPkg::frameBitsT [cfgPkg::NumberOfRows-1:0][cfgPkg::FramesPerRow-1:0] allFrames,
  input  cfgPkg::rowIdxT    readRow,
  input  cfgPkg::frameIdxT  readFrame,
  output cfgPkg::frameBitsT readData
);

  cfgPkg::frameBitsT [cfgPkg::FramesPerRow-1:0] rowData;

  // row first, then the frame inside it
  always_comb begin
    rowData = allFrames[readRow];
  end

  always_comb begin
    readData = rowData[readFrame];
  end

endmodule

//--- rtl/efpgaConfig.sv
`timescale 1ns/1ps

module efpgaConfig (
  input  logic              CLK,
  input  logic              rstN,
  input  logic              Rx,
  input  logic              s_clk,
  input  logic              s_data,
  input  cfgPkg::cfgWordT   SelfWriteData,
  input  logic              SelfWriteStrobe,
  input  cfgPkg::rowIdxT    readRow,
  input  cfgPkg::frameIdxT  readFrame,
  output logic              ComActive,
  output logic              ReceiveLED,
  output logic              LongFrameStrobe,
  output cfgPkg::rowIdxT    RowSelect,
  output cfgPkg::frameBitsT FrameAddressRegister,
  output cfgPkg::frameBitsT readData
);

  cfgPkg::cfgWordT uartWord;
  logic uartStrobe;
  logic uartActive;
  logic uartLed;
  cfgPkg::cfgWordT bbWord;
  logic bbStrobe;
  logic bbActive;
  cfgPkg::cfgWordT writeData;
  logic writeStrobe;
  logic fsmReset;
  cfgPkg::frameIdxT frameSel;
  cfgPkg::frameBitsT [cfgPkg::NumberOfRows-1:0][cfgPkg::FramesPerRow-1:0] allFrames;

  configUart uartPort (
    .CLK(CLK),
    .rstN(rstN),
    .Rx(Rx),
    .uartWord(uartWord),
    .uartStrobe(uartStrobe),
    .uartActive(uartActive),
    .uartLed(uartLed)
  );

  bitbangRx bitbangPort (
    .CLK(CLK),
    .rstN(rstN),
    .s_clk(s_clk),
    .s_data(s_data),
    .bbWord(bbWord),
    .bbStrobe(bbStrobe),
    .bbActive(bbActive)
  );

  // uart wins over bit-bang, bit-bang over the cpu port
  always_comb begin
    if (uartActive) begin
      writeData = uartWord;
      writeStrobe = uartStrobe;
    end else if (bbActive) begin
      writeData = bbWord;
      writeStrobe = bbStrobe;
    end else begin
      writeData = SelfWriteData;
      writeStrobe = SelfWriteStrobe;
    end
  end

  assign fsmReset = uartActive | bbActive;
  assign ComActive = uartActive;
  assign ReceiveLED = uartLed ^ bbStrobe;

  configFsm fsm (
    .CLK(CLK),
    .rstN(rstN),
    .WriteData(writeData),
    .WriteStrobe(writeStrobe),
    .FSM_Reset(fsmReset),
    .FrameAddressRegister(FrameAddressRegister),
    .RowSelect(RowSelect),
    .frameSel(frameSel),
    .LongFrameStrobe(LongFrameStrobe)
  );

  for (genvar r = 0; r < cfgPkg::NumberOfRows; r++) begin : gRow
    frameRowLatch rowLatch (
      .CLK(CLK),
      .rstN(rstN),
      .rowId(cfgPkg::rowIdxT'(r)),
      .RowSelect(RowSelect),
      .frameSel(frameSel),
      .LongFrameStrobe(LongFrameStrobe),
      .FrameAddressRegister(FrameAddressRegister),
      .rowFrames(allFrames[r])
    );
  end

  frameReadback readback (
    .allFrames(allFrames),
    .readRow(readRow),
    .readFrame(readFrame),
    .readData(readData)
  );

endmodule

//--- verif/efpgaConfigTb.sv
`timescale 1ns/1ps

module efpgaConfigTb;

  typedef enum {mSync, mHeader, mData} modelStateT;

  logic CLK;
  logic rstN;
  logic Rx;
  logic s_clk;
  logic s_data;
  cfgPkg::cfgWordT SelfWriteData;
  logic SelfWriteStrobe;
  cfgPkg::rowIdxT readRow;
  cfgPkg::frameIdxT readFrame;
  logic ComActive;
  logic ReceiveLED;
  logic LongFrameStrobe;
  cfgPkg::rowIdxT RowSelect;
  cfgPkg::frameBitsT FrameAddressRegister;
  cfgPkg::frameBitsT readData;

  integer seed;
  int errors = 0;
  int checks = 0;
  int checkerErrors = 0;
  int checkerChecks = 0;
  int seenStrobes = 0;
  int ledRises = 0;
  logic ledDly = 1'b0;

  // reference state
  modelStateT mState;
  cfgPkg::rowIdxT mRow;
  cfgPkg::frameIdxT mFrame;
  cfgPkg::frameBitsT model [4][4];
  cfgPkg::frameBitsT expFar [$];
  cfgPkg::rowIdxT expRow [$];

  efpgaConfig dut0 (
    .CLK(CLK),
    .rstN(rstN),
    .Rx(Rx),
    .s_clk(s_clk),
    .s_data(s_data),
    .SelfWriteData(SelfWriteData),
    .SelfWriteStrobe(SelfWriteStrobe),
    .readRow(readRow),
    .readFrame(readFrame),
    .ComActive(ComActive),
    .ReceiveLED(ReceiveLED),
    .LongFrameStrobe(LongFrameStrobe),
    .RowSelect(RowSelect),
    .FrameAddressRegister(FrameAddressRegister),
    .readData(readData)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // sync, then header and data pairs, desync bit in the header
  function automatic void applyWord(input cfgPkg::cfgWordT w);
    case (mState)
      mSync: begin
        if (w == 32'hFAB0FAB1) begin
          mState = mHeader;
        end
      end
      mHeader: begin
        if (w[20]) begin
          mState = mSync;
        end else begin
          mRow = w[31:30];
          mFrame = w[1:0];
          mState = mData;
        end
      end
      default: begin
        model[mRow][mFrame] = w;
        expFar.push_back(w);
        expRow.push_back(mRow);
        mState = mHeader;
      end
    endcase
  endfunction

  // serial session start puts the FSM back to sync search
  function automatic void modelResync();
    mState = mSync;
  endfunction

  function automatic cfgPkg::cfgWordT makeHeader(input cfgPkg::rowIdxT row,
      input cfgPkg::frameIdxT frame, input bit desync, input cfgPkg::cfgWordT fill);
    cfgPkg::cfgWordT h;
    h = fill;
    h[31:30] = row;
    h[1:0] = frame;
    h[20] = desync;
    return h;
  endfunction

  task automatic tick();
    @(posedge CLK);
    #5;
  endtask

  task automatic cpuWord(input cfgPkg::cfgWordT w, input bit toModel);
    SelfWriteData = w;
    SelfWriteStrobe = 1'b1;
    if (toModel) begin
      applyWord(w);
    end
    tick();
    SelfWriteStrobe = 1'b0;
    tick();
  endtask

  task automatic cpuPair(input bit toModel);
    logic [31:0] r;
    cfgPkg::rowIdxT row;
    cfgPkg::frameIdxT frame;
    cfgPkg::cfgWordT data;
    r = $random(seed);
    row = r[1:0];
    frame = r[3:2];
    data = $random(seed);
    cpuWord(makeHeader(row, frame, 1'b0, $random(seed)), toModel);
    readRow = row;
    readFrame = frame;
    SelfWriteData = data;
    SelfWriteStrobe = 1'b1;
    if (toModel) begin
      applyWord(data);
    end
    tick();
    SelfWriteStrobe = 1'b0;
    tick();
    // new frame visible two cycles after the data strobe
    checks++;
    assert (readData == model[row][frame]) else begin
      errors++;
      $display("ERR %0t: cpu write row %0d frame %0d read %h expected %h",
        $time, row, frame, readData, model[row][frame]);
    end
  endtask

  task automatic uartByte(input logic [7:0] b);
    logic [7:0] sh;
    sh = b;
    Rx = 1'b0;
    repeat (cfgPkg::ClocksPerBit) tick();
    for (int i = 0; i < 8; i++) begin
      Rx = sh[0];
      sh = {1'b0, sh[7:1]};
      repeat (cfgPkg::ClocksPerBit) tick();
    end
    // stop bit plus one idle bit
    Rx = 1'b1;
    repeat (2 * cfgPkg::ClocksPerBit) tick();
  endtask

  task automatic uartWordSend(input cfgPkg::cfgWordT w);
    applyWord(w);
    uartByte(w[31:24]);
    uartByte(w[23:16]);
    uartByte(w[15:8]);
    uartByte(w[7:0]);
  endtask

  task automatic bbWordSend(input cfgPkg::cfgWordT w, input bit toModel);
    cfgPkg::cfgWordT sh;
    sh = w;
    if (toModel) begin
      applyWord(w);
    end
    for (int i = 0; i < 32; i++) begin
      s_data = sh[31];
      sh = {sh[30:0], 1'b0};
      repeat (4) tick();
      s_clk = 1'b1;
      repeat (4) tick();
      s_clk = 1'b0;
    end
  endtask

  task automatic waitWritesDone(input int limit);
    int n;
    n = 0;
    while (seenStrobes != expFar.size() && n < limit) begin
      tick();
      n++;
    end
    if (seenStrobes != expFar.size()) begin
      errors++;
      $display("timed out after %0d cycles waiting for frame writes (%0d of %0d seen)",
        limit, seenStrobes, expFar.size());
    end
    tick();
  endtask

  task automatic sweepFrames();
    logic [3:0] idx;
    for (int i = 0; i < 16; i++) begin
      idx = 4'(i);
      readRow = idx[3:2];
      readFrame = idx[1:0];
      tick();
      checks++;
      assert (readData == model[idx[3:2]][idx[1:0]]) else begin
        errors++;
        $display("ERR %0t: readback row %0d frame %0d got %h expected %h",
          $time, idx[3:2], idx[1:0], readData, model[idx[3:2]][idx[1:0]]);
      end
    end
  endtask

  // one expected entry per LongFrameStrobe
  always @(negedge CLK) begin
    if (rstN && LongFrameStrobe) begin
      assert (seenStrobes < expFar.size()) else begin
        checkerErrors++;
        $display("a frame write strobe came that no word should have caused, at %0t", $time);
      end
      if (seenStrobes < expFar.size()) begin
        checkerChecks++;
        assert (FrameAddressRegister == expFar[seenStrobes] &&
            RowSelect == expRow[seenStrobes]) else begin
          checkerErrors++;
          $display("ERR %0t: frame write row %0d data %h expected row %0d data %h", $time,
            RowSelect, FrameAddressRegister, expRow[seenStrobes], expFar[seenStrobes]);
        end
        seenStrobes++;
      end
    end
  end

  always @(negedge CLK) begin
    ledDly <= ReceiveLED;
    if (ReceiveLED && !ledDly) begin
      ledRises <= ledRises + 1;
    end
  end

  initial begin
    int n;
    int ledBefore;
    logic [31:0] r;
    seed = 32'h0aafdf14;
    rstN = 1'b0;
    Rx = 1'b1;
    s_clk = 1'b0;
    s_data = 1'b0;
    SelfWriteData = '0;
    SelfWriteStrobe = 1'b0;
    readRow = '0;
    readFrame = '0;
    mState = mSync;
    mRow = '0;
    mFrame = '0;
    model = '{default: '0};
    repeat (16) @(posedge CLK);
    #5;
    rstN = 1'b1;
    tick();

    checks++;
    assert (!ComActive && !ReceiveLED && !LongFrameStrobe) else begin
      errors++;
      $display("ERR %0t: outputs not idle after reset", $time);
    end
    sweepFrames();

    // data before any sync is dropped
    repeat (3) cpuWord($random(seed), 1'b1);
    sweepFrames();

    cpuWord(cfgPkg::SyncWord, 1'b1);
    repeat (8) cpuPair(1'b1);
    waitWritesDone(50);
    sweepFrames();

    // desync header, then pairs that must not land
    cpuWord(makeHeader(2'd1, 2'd2, 1'b1, $random(seed)), 1'b1);
    repeat (3) cpuPair(1'b1);
    sweepFrames();
    cpuWord(cfgPkg::SyncWord, 1'b1);
    repeat (2) cpuPair(1'b1);
    waitWritesDone(50);
    sweepFrames();

    // bit-bang session
    ledBefore = ledRises;
    modelResync();
    bbWordSend(cfgPkg::SyncWord, 1'b1);
    repeat (2) begin
      r = $random(seed);
      bbWordSend(makeHeader(r[1:0], r[3:2], 1'b0, $random(seed)), 1'b1);
      bbWordSend($random(seed), 1'b1);
    end
    waitWritesDone(100);
    // cpu pair is lost while the port is still active
    cpuPair(1'b0);
    sweepFrames();
    checks++;
    assert (ledRises - ledBefore == 5) else begin
      errors++;
      $display("ERR %0t: ReceiveLED pulsed %0d times for 5 bit-bang words",
        $time, ledRises - ledBefore);
    end
    repeat (cfgPkg::BitbangIdleClocks + 8) tick();
    cpuPair(1'b1);
    waitWritesDone(50);

    // uart session with a bit-bang session running under it
    modelResync();
    fork
      begin
        uartByte(cfgPkg::UartSyncByte);
        checks++;
        assert (ComActive) else begin
          errors++;
          $display("ERR %0t: ComActive low after the sync byte", $time);
        end
        uartWordSend(cfgPkg::SyncWord);
        repeat (2) begin
          r = $random(seed);
          uartWordSend(makeHeader(r[1:0], r[3:2], 1'b0, $random(seed)));
          uartWordSend($random(seed));
        end
      end
      begin
        repeat (120) tick();
        repeat (2) bbWordSend($random(seed), 1'b0);
      end
    join
    waitWritesDone(200);
    sweepFrames();

    n = 0;
    while (ComActive && n < 400) begin
      tick();
      n++;
    end
    checks++;
    assert (!ComActive) else begin
      errors++;
      $display("ComActive did not fall within 400 cycles of the UART line going idle");
    end
    waitWritesDone(20);

    $display("checks %0d, errors %0d", checks + checkerChecks, errors + checkerErrors);
    if (errors + checkerErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- efpgaConfig.f
rtl/cfgPkg.sv
rtl/configUart.sv
rtl/bitbangRx.sv
rtl/configFsm.sv
rtl/frameRowLatch.sv
rtl/frameReadback.sv
rtl/efpgaConfig.sv
verif/efpgaConfigTb.sv

//--- runSim.sh
#!/bin/sh
# compile and run the efpgaConfig testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f efpgaConfig.f \
  --top-module efpgaConfigTb \
  -o efpgaConfigSim

./obj_dir/efpgaConfigSim > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"
